// ==== Bender.yml ====
package:
  name: rv32_control

sources:
  - hw/rv32_pkg.sv
  - hw/rv32_field_tracker.sv
  - hw/rv32_bus_ports.sv
  - hw/rv32_hazard_unit.sv
  - hw/rv32_control.sv
  - target: test
    files:
      - test/rv32_control_checks.sv
      - test/rv32_control_tb.sv

// ==== filelist.f ====
hw/rv32_pkg.sv
hw/rv32_field_tracker.sv
hw/rv32_bus_ports.sv
hw/rv32_hazard_unit.sv
hw/rv32_control.sv
test/rv32_control_checks.sv
test/rv32_control_tb.sv

// ==== hw/rv32_bus_ports.sv ====
`timescale 1ns/1ps

module rv32_bus_ports (
    input  logic clk,
    input  logic reset,

    input  logic instr_req,
    input  logic [rv32_pkg::xlen-1:0] instr_addr,
    input  logic data_read,
    input  logic data_write,
    input  logic [rv32_pkg::xlen-1:0] data_addr,

    output logic iwb_cyc,
    output logic iwb_stb,
    output logic [rv32_pkg::xlen-1:0] iwb_adr,
    input  logic iwb_ack,
    input  logic [rv32_pkg::xlen-1:0] iwb_dat_rd,
    output logic [rv32_pkg::xlen-1:0] instr_rdata,

    output logic dwb_cyc,
    output logic dwb_stb,
    output logic dwb_we,
    output logic [rv32_pkg::xlen-1:0] dwb_adr,
    input  logic dwb_ack,

    output logic instr_read,
    output logic instr_ready,
    output logic data_read_active,
    output logic data_write_active,
    output logic data_ready
);
    logic instr_busy;
    logic data_busy;

    // Instruction port.
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_busy <= 1'b0;
        end else if (instr_busy) begin
            if (iwb_ack) begin
                instr_busy <= 1'b0; // Drops the cycle after ack.
            end
        end else if (instr_req) begin
            instr_busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!instr_busy && instr_req) begin
            iwb_adr <= instr_addr; // Captured at cycle start.
        end
    end

    assign iwb_cyc = instr_busy;
    assign iwb_stb = instr_busy;
    assign instr_rdata = iwb_dat_rd;
    assign instr_read = instr_busy;
    assign instr_ready = iwb_ack;

    // Data port.
    always_ff @(posedge clk) begin
        if (reset) begin
            data_busy <= 1'b0;
            dwb_we <= 1'b0;
        end else if (data_busy) begin
            if (dwb_ack) begin
                data_busy <= 1'b0;
            end
        end else if (data_read || data_write) begin
            data_busy <= 1'b1;
            dwb_we <= data_write; // Write wins if both are asked.
        end
    end

    always_ff @(posedge clk) begin
        if (!data_busy && (data_read || data_write)) begin
            dwb_adr <= data_addr;
        end
    end

    assign dwb_cyc = data_busy;
    assign dwb_stb = data_busy;
    assign data_read_active = data_busy && !dwb_we;
    assign data_write_active = data_busy && dwb_we;
    assign data_ready = dwb_ack;

    iwb_stb_cyc_a: assert property (@(posedge clk) disable iff (reset)
        iwb_stb |-> iwb_cyc)
        else $error("iwb_stb without iwb_cyc");

    iwb_hold_a: assert property (@(posedge clk) disable iff (reset)
        iwb_stb && !iwb_ack |=> iwb_stb && $stable(iwb_adr))
        else $error("iwb request changed before ack");

    dwb_stb_cyc_a: assert property (@(posedge clk) disable iff (reset)
        dwb_stb |-> dwb_cyc)
        else $error("dwb_stb without dwb_cyc");

    dwb_hold_a: assert property (@(posedge clk) disable iff (reset)
        dwb_stb && !dwb_ack |=> dwb_stb && $stable(dwb_adr) && $stable(dwb_we))
        else $error("dwb request changed before ack");

endmodule

// ==== hw/rv32_control.sv ====
`timescale 1ns/1ps

module rv32_control (
    input  logic clk,
    input  logic reset,

    input  rv32_pkg::rv32_instr_t fetch_instr,
    input  logic fetch_valid,
    input  logic fetch_overwrite_pc,
    input  logic mem_trap,
    input  logic mem_branch_mispredicted,

    input  logic instr_req,
    input  logic [rv32_pkg::xlen-1:0] instr_addr,
    output logic [rv32_pkg::xlen-1:0] instr_rdata,
    input  logic data_read,
    input  logic data_write,
    input  logic [rv32_pkg::xlen-1:0] data_addr,

    output logic iwb_cyc,
    output logic iwb_stb,
    output logic [rv32_pkg::xlen-1:0] iwb_adr,
    input  logic iwb_ack,
    input  logic [rv32_pkg::xlen-1:0] iwb_dat_rd,

    output logic dwb_cyc,
    output logic dwb_stb,
    output logic dwb_we,
    output logic [rv32_pkg::xlen-1:0] dwb_adr,
    input  logic dwb_ack,

    output logic pcgen_stall,
    output logic fetch_stall,
    output logic fetch_flush,
    output logic decode_stall,
    output logic decode_flush,
    output logic execute_stall,
    output logic execute_flush,
    output logic mem_flush,
    output logic writeback_flush
);
    logic [rv32_pkg::reg_addr_width-1:0] rs1_unreg;
    logic [rv32_pkg::reg_addr_width-1:0] rs2_unreg;
    logic rs1_read_unreg;
    logic rs2_read_unreg;
    logic mem_fence_unreg;
    logic [rv32_pkg::reg_addr_width-1:0] decode_rd;
    logic decode_rd_write;
    logic decode_mem_read;
    logic decode_csr_read;
    logic decode_mem_fence;
    logic execute_mem_fence;
    logic instr_read;
    logic instr_ready;
    logic data_read_active;
    logic data_write_active;
    logic data_ready;

    rv32_field_tracker u_field_tracker (
        .clk(clk),
        .reset(reset),
        .fetch_instr(fetch_instr),
        .fetch_valid(fetch_valid),
        .decode_stall(decode_stall),
        .decode_flush(decode_flush),
        .execute_stall(execute_stall),
        .execute_flush(execute_flush),
        .rs1_unreg(rs1_unreg),
        .rs2_unreg(rs2_unreg),
        .rs1_read_unreg(rs1_read_unreg),
        .rs2_read_unreg(rs2_read_unreg),
        .mem_fence_unreg(mem_fence_unreg),
        .decode_rd(decode_rd),
        .decode_rd_write(decode_rd_write),
        .decode_mem_read(decode_mem_read),
        .decode_csr_read(decode_csr_read),
        .decode_mem_fence(decode_mem_fence),
        .execute_mem_fence(execute_mem_fence)
    );

    rv32_bus_ports u_bus_ports (
        .clk(clk),
        .reset(reset),
        .instr_req(instr_req),
        .instr_addr(instr_addr),
        .data_read(data_read),
        .data_write(data_write),
        .data_addr(data_addr),
        .iwb_cyc(iwb_cyc),
        .iwb_stb(iwb_stb),
        .iwb_adr(iwb_adr),
        .iwb_ack(iwb_ack),
        .iwb_dat_rd(iwb_dat_rd),
        .instr_rdata(instr_rdata),
        .dwb_cyc(dwb_cyc),
        .dwb_stb(dwb_stb),
        .dwb_we(dwb_we),
        .dwb_adr(dwb_adr),
        .dwb_ack(dwb_ack),
        .instr_read(instr_read),
        .instr_ready(instr_ready),
        .data_read_active(data_read_active),
        .data_write_active(data_write_active),
        .data_ready(data_ready)
    );

    rv32_hazard_unit u_hazard_unit (
        .rs1_unreg(rs1_unreg),
        .rs1_read_unreg(rs1_read_unreg),
        .rs2_unreg(rs2_unreg),
        .rs2_read_unreg(rs2_read_unreg),
        .mem_fence_unreg(mem_fence_unreg),
        .decode_rd(decode_rd),
        .decode_rd_write(decode_rd_write),
        .decode_mem_read(decode_mem_read),
        .decode_csr_read(decode_csr_read),
        .decode_mem_fence(decode_mem_fence),
        .execute_mem_fence(execute_mem_fence),
        .instr_read(instr_read),
        .instr_ready(instr_ready),
        .data_read_active(data_read_active),
        .data_write_active(data_write_active),
        .data_ready(data_ready),
        .fetch_overwrite_pc(fetch_overwrite_pc),
        .mem_trap(mem_trap),
        .mem_branch_mispredicted(mem_branch_mispredicted),
        .pcgen_stall(pcgen_stall),
        .fetch_stall(fetch_stall),
        .fetch_flush(fetch_flush),
        .decode_stall(decode_stall),
        .decode_flush(decode_flush),
        .execute_stall(execute_stall),
        .execute_flush(execute_flush),
        .mem_flush(mem_flush),
        .writeback_flush(writeback_flush)
    );

endmodule

// ==== hw/rv32_field_tracker.sv ====
`timescale 1ns/1ps

module rv32_field_tracker (
    input  logic clk,
    input  logic reset,

    input  rv32_pkg::rv32_instr_t fetch_instr,
    input  logic fetch_valid,

    input  logic decode_stall,
    input  logic decode_flush,
    input  logic execute_stall,
    input  logic execute_flush,

    output logic [rv32_pkg::reg_addr_width-1:0] rs1_unreg,
    output logic [rv32_pkg::reg_addr_width-1:0] rs2_unreg,
    output logic rs1_read_unreg,
    output logic rs2_read_unreg,
    output logic mem_fence_unreg,

    output logic [rv32_pkg::reg_addr_width-1:0] decode_rd,
    output logic decode_rd_write,
    output logic decode_mem_read,
    output logic decode_csr_read,
    output logic decode_mem_fence,

    output logic execute_mem_fence
);
    logic [rv32_pkg::opcode_width-1:0] opcode;
    logic [rv32_pkg::funct3_width-1:0] sys_funct3;
    logic [rv32_pkg::reg_addr_width-1:0] rd_unreg;
    logic csr_access;
    logic rd_write_unreg;
    logic mem_read_unreg;
    logic csr_read_unreg;

    assign opcode = fetch_instr.r_view.opcode;
    assign sys_funct3 = fetch_instr.i_view.funct3;
    assign csr_access = sys_funct3 != rv32_pkg::funct3_priv;

    assign rs1_unreg = fetch_instr.r_view.rs1;
    assign rs2_unreg = fetch_instr.r_view.rs2;
    assign rd_unreg = fetch_instr.r_view.rd;

    always_comb begin
        rs1_read_unreg = 1'b0;
        rs2_read_unreg = 1'b0;
        rd_write_unreg = 1'b0;
        mem_read_unreg = 1'b0;
        csr_read_unreg = 1'b0;
        mem_fence_unreg = 1'b0;

        if (fetch_valid) begin
            case (opcode)
                rv32_pkg::opcode_lui, rv32_pkg::opcode_auipc, rv32_pkg::opcode_jal: begin
                    rd_write_unreg = 1'b1;
                end
                rv32_pkg::opcode_jalr, rv32_pkg::opcode_op_imm: begin
                    rs1_read_unreg = 1'b1;
                    rd_write_unreg = 1'b1;
                end
                rv32_pkg::opcode_branch, rv32_pkg::opcode_store: begin
                    rs1_read_unreg = 1'b1;
                    rs2_read_unreg = 1'b1;
                end
                rv32_pkg::opcode_load: begin
                    rs1_read_unreg = 1'b1;
                    rd_write_unreg = 1'b1;
                    mem_read_unreg = 1'b1;
                end
                rv32_pkg::opcode_op: begin
                    rs1_read_unreg = 1'b1;
                    rs2_read_unreg = 1'b1;
                    rd_write_unreg = 1'b1;
                end
                rv32_pkg::opcode_misc_mem: begin
                    mem_fence_unreg = 1'b1;
                end
                rv32_pkg::opcode_system: begin
                    if (csr_access) begin
                        rs1_read_unreg = !sys_funct3[2]; // Immediate forms use zimm.
                        rd_write_unreg = 1'b1;
                        csr_read_unreg = 1'b1;
                    end
                end
                default: begin
                    rd_write_unreg = 1'b0; // Unknown opcode is a bubble.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || (decode_flush && !decode_stall)) begin
            decode_rd <= '0;
            decode_rd_write <= 1'b0;
            decode_mem_read <= 1'b0;
            decode_csr_read <= 1'b0;
            decode_mem_fence <= 1'b0;
        end else if (!decode_stall) begin
            decode_rd <= rd_unreg;
            decode_rd_write <= rd_write_unreg;
            decode_mem_read <= mem_read_unreg;
            decode_csr_read <= csr_read_unreg;
            decode_mem_fence <= mem_fence_unreg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || (execute_flush && !execute_stall)) begin
            execute_mem_fence <= 1'b0;
        end else if (!execute_stall) begin
            execute_mem_fence <= decode_mem_fence;
        end
    end

    // A held decode entry is a load or a CSR access, never both.
    decode_class_a: assert property (@(posedge clk) disable iff (reset)
        !(decode_mem_read && decode_csr_read))
        else $error("decode stage holds both mem_read and csr_read");

endmodule

// ==== hw/rv32_hazard_unit.sv ====
`timescale 1ns/1ps

module rv32_hazard_unit (
    input  logic [rv32_pkg::reg_addr_width-1:0] rs1_unreg,
    input  logic rs1_read_unreg,
    input  logic [rv32_pkg::reg_addr_width-1:0] rs2_unreg,
    input  logic rs2_read_unreg,
    input  logic mem_fence_unreg,

    input  logic [rv32_pkg::reg_addr_width-1:0] decode_rd,
    input  logic decode_rd_write,
    input  logic decode_mem_read,
    input  logic decode_csr_read,
    input  logic decode_mem_fence,

    input  logic execute_mem_fence,

    input  logic instr_read,
    input  logic instr_ready,
    input  logic data_read_active,
    input  logic data_write_active,
    input  logic data_ready,

    input  logic fetch_overwrite_pc,
    input  logic mem_trap,
    input  logic mem_branch_mispredicted,

    output logic pcgen_stall,
    output logic fetch_stall,
    output logic fetch_flush,
    output logic decode_stall,
    output logic decode_flush,
    output logic execute_stall,
    output logic execute_flush,
    output logic mem_flush,
    output logic writeback_flush
);
    logic rs1_match;
    logic rs2_match;
    logic load_use;
    logic fence_pending;
    logic instr_wait;
    logic data_wait;
    logic redirect;
    logic mem_stall;

    assign rs1_match = rs1_read_unreg && rs1_unreg == decode_rd;
    assign rs2_match = rs2_read_unreg && rs2_unreg == decode_rd;

    // Result of a load or CSR read is not ready for the next instruction.
    assign load_use = (rs1_match || rs2_match) && |decode_rd && decode_rd_write
        && (decode_mem_read || decode_csr_read);

    assign fence_pending = mem_fence_unreg || decode_mem_fence || execute_mem_fence;
    assign instr_wait = instr_read && !instr_ready;
    assign data_wait = (data_read_active || data_write_active) && !data_ready;
    assign redirect = mem_trap || mem_branch_mispredicted || fetch_overwrite_pc;

    assign mem_stall = 1'b0; // Memory stage never waits.

    assign execute_stall = mem_stall || data_wait;
    assign decode_stall = execute_stall;
    assign fetch_stall = decode_stall || load_use || fence_pending;
    assign pcgen_stall = fetch_stall || instr_wait;

    // Bubble into a stage whose predecessor is held.
    assign fetch_flush = pcgen_stall || redirect;
    assign decode_flush = fetch_stall || redirect;
    assign execute_flush = decode_stall || redirect;
    assign mem_flush = execute_stall;
    assign writeback_flush = mem_stall;

    stall_chain_a: assert #0 (!decode_stall || fetch_stall)
        else $error("decode stalled while fetch runs");

endmodule

// ==== hw/rv32_pkg.sv ====
package rv32_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int opcode_width = 7;
    localparam int funct3_width = 3;
    localparam int funct7_width = 7;
    localparam int imm_i_width = 12;

    // Major opcodes, RV32I base set.
    localparam logic [opcode_width-1:0] opcode_lui = 7'b0110111;
    localparam logic [opcode_width-1:0] opcode_auipc = 7'b0010111;
    localparam logic [opcode_width-1:0] opcode_jal = 7'b1101111;
    localparam logic [opcode_width-1:0] opcode_jalr = 7'b1100111;
    localparam logic [opcode_width-1:0] opcode_branch = 7'b1100011;
    localparam logic [opcode_width-1:0] opcode_load = 7'b0000011;
    localparam logic [opcode_width-1:0] opcode_store = 7'b0100011;
    localparam logic [opcode_width-1:0] opcode_op_imm = 7'b0010011;
    localparam logic [opcode_width-1:0] opcode_op = 7'b0110011;
    localparam logic [opcode_width-1:0] opcode_misc_mem = 7'b0001111;
    localparam logic [opcode_width-1:0] opcode_system = 7'b1110011;

    localparam logic [funct3_width-1:0] funct3_priv = 3'b000; // Ecall and ebreak.

    typedef struct packed {
        logic [funct7_width-1:0] funct7;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [funct3_width-1:0] funct3;
        logic [reg_addr_width-1:0] rd;
        logic [opcode_width-1:0] opcode;
    } rv32_r_view_t;

    typedef struct packed {
        logic [imm_i_width-1:0] imm; // CSR address for system class.
        logic [reg_addr_width-1:0] rs1;
        logic [funct3_width-1:0] funct3;
        logic [reg_addr_width-1:0] rd;
        logic [opcode_width-1:0] opcode;
    } rv32_i_view_t;

    // Same 32-bit word, register view or immediate view.
    typedef union packed {
        rv32_r_view_t r_view;
        rv32_i_view_t i_view;
    } rv32_instr_t;

endpackage

// ==== test/rv32_control_checks.sv ====
`timescale 1ns/1ps

module rv32_control_checks (
    input  logic clk,
    input  logic reset,
    input  rv32_pkg::rv32_instr_t fetch_instr,
    input  logic fetch_valid,
    input  logic fetch_overwrite_pc,
    input  logic mem_trap,
    input  logic mem_branch_mispredicted,
    input  logic instr_req,
    input  logic [rv32_pkg::xlen-1:0] instr_addr,
    input  logic [rv32_pkg::xlen-1:0] instr_rdata,
    input  logic data_read,
    input  logic data_write,
    input  logic [rv32_pkg::xlen-1:0] data_addr,
    input  logic iwb_cyc,
    input  logic iwb_stb,
    input  logic [rv32_pkg::xlen-1:0] iwb_adr,
    input  logic iwb_ack,
    input  logic [rv32_pkg::xlen-1:0] iwb_dat_rd,
    input  logic dwb_cyc,
    input  logic dwb_stb,
    input  logic dwb_we,
    input  logic [rv32_pkg::xlen-1:0] dwb_adr,
    input  logic dwb_ack,
    input  logic pcgen_stall,
    input  logic fetch_stall,
    input  logic fetch_flush,
    input  logic decode_stall,
    input  logic decode_flush,
    input  logic execute_stall,
    input  logic execute_flush,
    input  logic mem_flush,
    input  logic writeback_flush,
    output int value_errors,
    output int bus_errors
);
    logic [rv32_pkg::opcode_width-1:0] opcode;
    logic [rv32_pkg::funct3_width-1:0] funct3;
    logic is_load;
    logic is_csr;
    logic is_fence;
    logic reads_rs1;
    logic reads_rs2;
    logic [rv32_pkg::reg_addr_width-1:0] ref_rd;
    logic ref_result_late; // Load or CSR read sitting in decode.
    logic ref_decode_fence;
    logic ref_execute_fence;
    logic hazard;
    logic redirect;
    logic data_wait;
    logic instr_wait;
    logic exp_fetch_stall;
    logic reset_q = 1'b0;

    initial begin
        value_errors = 0;
        bus_errors = 0;
    end

    task automatic record_failure(input bit bus_side, input string msg);
        if (bus_side) begin
            bus_errors++;
        end else begin
            value_errors++;
        end
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    assign opcode = fetch_instr.r_view.opcode;
    assign funct3 = fetch_instr.i_view.funct3;
    assign is_load = fetch_valid && opcode == rv32_pkg::opcode_load;
    assign is_csr = fetch_valid && opcode == rv32_pkg::opcode_system && funct3 != 3'b000;
    assign is_fence = fetch_valid && opcode == rv32_pkg::opcode_misc_mem;
    assign reads_rs2 = fetch_valid
        && (opcode == rv32_pkg::opcode_op || opcode == rv32_pkg::opcode_store);
    assign reads_rs1 = reads_rs2 || is_load || (is_csr && !funct3[2])
        || (fetch_valid && opcode == rv32_pkg::opcode_op_imm);

    assign hazard = ref_result_late && ref_rd != '0
        && ((reads_rs1 && fetch_instr.r_view.rs1 == ref_rd)
        || (reads_rs2 && fetch_instr.r_view.rs2 == ref_rd));
    assign redirect = mem_trap || mem_branch_mispredicted || fetch_overwrite_pc;
    assign data_wait = dwb_cyc && !dwb_ack;
    assign instr_wait = iwb_cyc && !iwb_ack;
    assign exp_fetch_stall = data_wait || hazard || is_fence
        || ref_decode_fence || ref_execute_fence;

    // Reference decode and execute stages.
    always @(posedge clk) begin
        reset_q <= reset;
        if (reset || (decode_flush && !decode_stall)) begin
            ref_rd <= '0;
            ref_result_late <= 1'b0;
            ref_decode_fence <= 1'b0;
        end else if (!decode_stall) begin
            ref_rd <= fetch_instr.r_view.rd;
            ref_result_late <= is_load || is_csr;
            ref_decode_fence <= is_fence;
        end
        if (reset || (execute_flush && !execute_stall)) begin
            ref_execute_fence <= 1'b0;
        end else if (!execute_stall) begin
            ref_execute_fence <= ref_decode_fence;
        end
    end

    // Covers the reset cycles and the first cycle after reset.
    reset_idle_a: assert property (@(posedge clk) reset_q
        |-> !iwb_cyc && !iwb_stb && !dwb_cyc && !dwb_stb && !fetch_stall)
        else record_failure(1'b1, "bus cycle or stall active during or just after reset");

    fetch_stall_a: assert property (@(posedge clk) disable iff (reset)
        fetch_stall == exp_fetch_stall && decode_flush == (exp_fetch_stall || redirect))
        else record_failure(1'b0, "fetch_stall or decode_flush differs from hazard rules");

    pcgen_stall_a: assert property (@(posedge clk) disable iff (reset)
        pcgen_stall == (exp_fetch_stall || instr_wait)
        && fetch_flush == (exp_fetch_stall || instr_wait || redirect))
        else record_failure(1'b0, "pcgen_stall or fetch_flush wrong");

    data_wait_a: assert property (@(posedge clk) disable iff (reset)
        execute_stall == data_wait && decode_stall == data_wait && mem_flush == data_wait
        && execute_flush == (data_wait || redirect) && !writeback_flush)
        else record_failure(1'b0, "execute side stall or flush wrong");

    redirect_a: assert property (@(posedge clk) disable iff (reset)
        redirect |-> fetch_flush && decode_flush && execute_flush)
        else record_failure(1'b0, "redirect did not flush fetch, decode and execute");

    rdata_pass_a: assert property (@(posedge clk) disable iff (reset)
        instr_rdata == iwb_dat_rd)
        else record_failure(1'b1, "instr_rdata differs from iwb_dat_rd");

    iwb_start_a: assert property (@(posedge clk) disable iff (reset)
        !iwb_cyc && instr_req |=> iwb_cyc && iwb_stb && iwb_adr == $past(instr_addr))
        else record_failure(1'b1, "instruction cycle did not open on request");

    iwb_hold_a: assert property (@(posedge clk) disable iff (reset)
        iwb_cyc && !iwb_ack |=> iwb_cyc && iwb_stb && $stable(iwb_adr))
        else record_failure(1'b1, "instruction cycle changed before ack");

    iwb_end_a: assert property (@(posedge clk) disable iff (reset)
        iwb_cyc && iwb_ack |=> !iwb_cyc && !iwb_stb)
        else record_failure(1'b1, "instruction cycle still open after ack");

    dwb_start_a: assert property (@(posedge clk) disable iff (reset)
        !dwb_cyc && (data_read || data_write) |=> dwb_cyc && dwb_stb
        && dwb_we == $past(data_write) && dwb_adr == $past(data_addr))
        else record_failure(1'b1, "data cycle did not open as requested");

    dwb_hold_a: assert property (@(posedge clk) disable iff (reset)
        dwb_cyc && !dwb_ack |=> dwb_cyc && dwb_stb && $stable(dwb_we) && $stable(dwb_adr))
        else record_failure(1'b1, "data cycle changed before ack");

    dwb_end_a: assert property (@(posedge clk) disable iff (reset)
        dwb_cyc && dwb_ack |=> !dwb_cyc && !dwb_stb)
        else record_failure(1'b1, "data cycle still open after ack");

endmodule

// ==== test/rv32_control_tb.sv ====
`timescale 1ns/1ps

module rv32_control_tb;
    localparam time clk_period = 100ns;
    localparam int directed_cycles = 80;
    localparam int random_cycles = 200;
    localparam int test_cycles = directed_cycles + random_cycles;

    logic clk = 1'b0;
    logic reset;
    rv32_pkg::rv32_instr_t fetch_instr;
    logic fetch_valid;
    logic fetch_overwrite_pc;
    logic mem_trap;
    logic mem_branch_mispredicted;
    logic instr_req;
    logic [rv32_pkg::xlen-1:0] instr_addr;
    logic [rv32_pkg::xlen-1:0] instr_rdata;
    logic data_read;
    logic data_write;
    logic [rv32_pkg::xlen-1:0] data_addr;
    logic iwb_cyc;
    logic iwb_stb;
    logic [rv32_pkg::xlen-1:0] iwb_adr;
    logic iwb_ack = 1'b0;
    logic [rv32_pkg::xlen-1:0] iwb_dat_rd = '0;
    logic dwb_cyc;
    logic dwb_stb;
    logic dwb_we;
    logic [rv32_pkg::xlen-1:0] dwb_adr;
    logic dwb_ack = 1'b0;
    logic pcgen_stall;
    logic fetch_stall;
    logic fetch_flush;
    logic decode_stall;
    logic decode_flush;
    logic execute_stall;
    logic execute_flush;
    logic mem_flush;
    logic writeback_flush;
    int value_errors;
    int bus_errors;
    int seed = 32'h76d0;
    int draw [2];
    int wait_left [2];
    bit armed [2];

    rv32_control dut (.*);
    rv32_control_checks checks (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic rv32_pkg::rv32_instr_t encode(input logic [6:0] funct7,
        input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] funct3,
        input logic [4:0] rd, input logic [6:0] opcode);
        return {funct7, rs2, rs1, funct3, rd, opcode};
    endfunction

    task automatic next_cycle(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic issue(input rv32_pkg::rv32_instr_t word, input int n);
        fetch_instr = word;
        fetch_valid = 1'b1;
        next_cycle(n);
    endtask

    // Returns 5 ns after the edge that sampled ack.
    task automatic wait_for_ack(input bit data_side);
        @(posedge clk);
        while (!(data_side ? dwb_ack : iwb_ack)) begin
            @(posedge clk);
        end
        #5;
    endtask

    // Slave answer, 0 to 3 wait cycles per bus cycle.
    task automatic answer_bus(input int side, input logic cyc, inout logic ack);
        if (ack) begin
            ack = 1'b0;
            armed[side] = 1'b0;
        end else if (cyc) begin
            if (!armed[side]) begin
                wait_left[side] = $unsigned(draw[side]) % 4;
                armed[side] = 1'b1;
            end else begin
                wait_left[side] = wait_left[side] - 1;
            end
            ack = wait_left[side] == 0;
        end
    endtask

    always @(posedge clk) begin
        draw[0] = $random(seed);
        draw[1] = $random(seed);
        #5;
        iwb_dat_rd = draw[0];
        answer_bus(0, iwb_cyc, iwb_ack);
        answer_bus(1, dwb_cyc, dwb_ack);
    end

    task automatic random_cycle();
        int pick;
        logic [4:0] ra;
        logic [4:0] rb;
        pick = $unsigned($random(seed)) % 8;
        ra = $unsigned($random(seed)) % 8;
        rb = $unsigned($random(seed)) % 8;
        case (pick)
            0, 1: fetch_instr = encode(7'h00, 5'd0, rb, 3'b010, ra, rv32_pkg::opcode_load);
            2, 3: fetch_instr = encode(7'h00, rb, ra, 3'b000, rb, rv32_pkg::opcode_op);
            4: fetch_instr = encode(7'h60, 5'd0, rb, {ra[0], 2'b10}, ra, rv32_pkg::opcode_system);
            5: fetch_instr = encode(7'h00, 5'd0, 5'd0, 3'b000, ra, rv32_pkg::opcode_system);
            6: fetch_instr = encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, rv32_pkg::opcode_misc_mem);
            default: fetch_instr = encode(7'h00, ra, rb, 3'b010, 5'd0, rv32_pkg::opcode_store);
        endcase
        fetch_valid = ($unsigned($random(seed)) % 4) != 0;
        instr_req = ($unsigned($random(seed)) % 2) != 0;
        instr_addr = $random(seed);
        data_read = ($unsigned($random(seed)) % 8) == 0;
        data_write = ($unsigned($random(seed)) % 8) == 1;
        data_addr = $random(seed);
        mem_trap = ($unsigned($random(seed)) % 32) == 0;
        mem_branch_mispredicted = ($unsigned($random(seed)) % 32) == 0;
        fetch_overwrite_pc = ($unsigned($random(seed)) % 32) == 0;
        next_cycle(1);
    endtask

    initial begin
        #((test_cycles * 4 + 100) * clk_period);
        $display("Watchdog expired: run did not finish in %0d cycles", test_cycles * 4 + 100);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        fetch_instr = '0;
        fetch_valid = 1'b0;
        fetch_overwrite_pc = 1'b0;
        mem_trap = 1'b0;
        mem_branch_mispredicted = 1'b0;
        instr_req = 1'b0;
        instr_addr = '0;
        data_read = 1'b0;
        data_write = 1'b0;
        data_addr = '0;
        next_cycle(5);
        reset = 1'b0;
        next_cycle(2);

        // Load into x5, then consumers with and without a dependency.
        issue(encode(7'h00, 5'd0, 5'd1, 3'b010, 5'd5, rv32_pkg::opcode_load), 1);
        issue(encode(7'h00, 5'd2, 5'd5, 3'b000, 5'd6, rv32_pkg::opcode_op), 2);
        issue(encode(7'h00, 5'd0, 5'd1, 3'b010, 5'd0, rv32_pkg::opcode_load), 1);
        issue(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd6, rv32_pkg::opcode_op), 2);
        issue(encode(7'h00, 5'd0, 5'd1, 3'b010, 5'd5, rv32_pkg::opcode_load), 1);
        issue(encode(7'h00, 5'd8, 5'd7, 3'b000, 5'd6, rv32_pkg::opcode_op), 2);
        // CSR read of the cycle counter, then ecall with the same rd field.
        issue(encode(7'h60, 5'd0, 5'd0, 3'b010, 5'd5, rv32_pkg::opcode_system), 1);
        issue(encode(7'h00, 5'd2, 5'd5, 3'b000, 5'd6, rv32_pkg::opcode_op), 2);
        issue(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd5, rv32_pkg::opcode_system), 1);
        issue(encode(7'h00, 5'd2, 5'd5, 3'b000, 5'd6, rv32_pkg::opcode_op), 2);
        issue(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, rv32_pkg::opcode_misc_mem), 3);
        issue(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, rv32_pkg::opcode_op_imm), 3);
        fetch_valid = 1'b0;

        for (int i = 0; i < 4; i++) begin
            instr_req = 1'b1;
            instr_addr = 32'h0000_0100 + 4 * i;
            wait_for_ack(1'b0);
        end
        instr_req = 1'b0;
        data_read = 1'b1;
        data_addr = 32'h0000_2000;
        wait_for_ack(1'b1);
        data_read = 1'b0;
        data_write = 1'b1;
        data_addr = 32'h0000_2004;
        wait_for_ack(1'b1);
        data_write = 1'b0;
        next_cycle(2);

        mem_trap = 1'b1;
        next_cycle(1);
        mem_trap = 1'b0;
        mem_branch_mispredicted = 1'b1;
        next_cycle(1);
        mem_branch_mispredicted = 1'b0;
        fetch_overwrite_pc = 1'b1;
        next_cycle(1);
        fetch_overwrite_pc = 1'b0;

        repeat (random_cycles) begin
            random_cycle();
        end
        fetch_valid = 1'b0;
        instr_req = 1'b0;
        data_read = 1'b0;
        data_write = 1'b0;
        mem_trap = 1'b0;
        mem_branch_mispredicted = 1'b0;
        fetch_overwrite_pc = 1'b0;
        next_cycle(8);

        $display("Summary: %0d value errors, %0d bus errors", value_errors, bus_errors);
        if (value_errors == 0 && bus_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
